// File: verilog/mipsPkg.sv
package mipsPkg;

    // Word, register number and instruction field types
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [2:0]  aluOpT;

    //////////////////////////////////////////////////////////////////////
    // Primary opcodes
    //////////////////////////////////////////////////////////////////////
    localparam opcodeT opRtype = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opOri   = 6'h0d;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    // Function field of register type instructions
    localparam functT fnSll  = 6'h00;
    localparam functT fnAddu = 6'h21;
    localparam functT fnSubu = 6'h23;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnOr   = 6'h25;
    localparam functT fnSlt  = 6'h2a;

    // ALU operations
    localparam aluOpT aluAdd = 3'd0;
    localparam aluOpT aluSub = 3'd1;
    localparam aluOpT aluAnd = 3'd2;
    localparam aluOpT aluOr  = 3'd3;
    localparam aluOpT aluSlt = 3'd4;
    localparam aluOpT aluSll = 3'd5;

    // Memory depths in words
    localparam int imemWords    = 64;
    localparam int dmemWords    = 64;
    localparam int imemAddrBits = $clog2(imemWords);
    localparam int dmemAddrBits = $clog2(dmemWords);

    localparam regAddrT linkReg = 5'd31;
    localparam wordT    resetPc = 32'h0000_0000;

endpackage

// File: verilog/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic          Clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          redirect,
    input  mipsPkg::wordT redirectTarget,
    output mipsPkg::wordT instrD,
    output mipsPkg::wordT pcPlus4D
);
    import mipsPkg::*;

    wordT pcF;
    wordT pcPlus4F;
    wordT instrF;
    logic [imemAddrBits-1:0] imemIndex;

    // Instruction ROM
    wordT imem [imemWords];

    initial begin
        $readmemh("program.hex", imem);
    end

    assign pcPlus4F  = pcF + 32'd4;
    assign imemIndex = pcF[imemAddrBits+1:2];
    assign instrF    = imem[imemIndex];

    //////////////////////////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////////////////////////

    // Redirect wins, decode never asserts it while stalled
    always_ff @(posedge Clk) begin
        if (reset) begin
            pcF <= resetPc;
        end else if (redirect) begin
            pcF <= redirectTarget;
        end else if (!stall) begin
            pcF <= pcPlus4F;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch to decode register
    //////////////////////////////////////////////////////////////////////

    // All-zero word decodes as sll r0,r0,0
    always_ff @(posedge Clk) begin
        if (reset) begin
            instrD <= '0;
        end else if (redirect) begin
            instrD <= '0;
        end else if (!stall) begin
            instrD <= instrF;
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            pcPlus4D <= pcPlus4F;
        end
    end

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic             Clk,
    input  logic             reset,
    input  mipsPkg::wordT    instrD,
    input  mipsPkg::wordT    pcPlus4D,
    // Destinations still in flight
    input  mipsPkg::regAddrT writeRegEx,
    input  logic             regWriteEx,
    input  mipsPkg::regAddrT writeRegMem,
    input  logic             regWriteMem,
    // Register file write port
    input  logic             regWriteW,
    input  mipsPkg::regAddrT writeRegW,
    input  mipsPkg::wordT    writeDataW,
    // Back to fetch
    output logic             stall,
    output logic             redirect,
    output mipsPkg::wordT    redirectTarget,
    // Execute side
    output logic             regWriteE,
    output logic             memReadE,
    output logic             memWriteE,
    output logic             memToRegE,
    output logic             linkE,
    output mipsPkg::aluOpT   aluOpE,
    output logic             aluSrcE,
    output logic [4:0]       shamtE,
    output mipsPkg::wordT    readData1E,
    output mipsPkg::wordT    readData2E,
    output mipsPkg::wordT    immE,
    output mipsPkg::regAddrT writeRegE,
    output mipsPkg::wordT    pcPlus4E
);
    import mipsPkg::*;

    opcodeT  opcode;
    functT   funct;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    wordT    immD;
    wordT    readData1D;
    wordT    readData2D;
    wordT    branchTarget;
    wordT    jumpTarget;
    regAddrT writeRegD;
    aluOpT   aluOpD;
    logic    regWriteD;
    logic    memReadD;
    logic    memWriteD;
    logic    memToRegD;
    logic    linkD;
    logic    aluSrcD;
    logic    zeroExt;
    logic    useRd;
    logic    usesRt;
    logic    isBeq;
    logic    isBne;
    logic    isJump;
    logic    rsHazard;
    logic    rtHazard;
    logic    branchTaken;

    wordT regFile [32];

    assign opcode = instrD[31:26];
    assign rs     = instrD[25:21];
    assign rt     = instrD[20:16];
    assign rd     = instrD[15:11];
    assign funct  = instrD[5:0];

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        regWriteD = 1'b0;
        memReadD  = 1'b0;
        memWriteD = 1'b0;
        memToRegD = 1'b0;
        linkD     = 1'b0;
        aluSrcD   = 1'b0;
        aluOpD    = aluAdd;
        zeroExt   = 1'b0;
        useRd     = 1'b0;
        usesRt    = 1'b0;
        isBeq     = 1'b0;
        isBne     = 1'b0;
        isJump    = 1'b0;
        case (opcode)
            opRtype: begin
                regWriteD = 1'b1;
                useRd     = 1'b1;
                usesRt    = 1'b1;
                case (funct)
                    fnAddu:  aluOpD = aluAdd;
                    fnSubu:  aluOpD = aluSub;
                    fnAnd:   aluOpD = aluAnd;
                    fnOr:    aluOpD = aluOr;
                    fnSlt:   aluOpD = aluSlt;
                    fnSll:   aluOpD = aluSll;
                    default: regWriteD = 1'b0;
                endcase
            end
            opAddiu: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            opOri: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = aluOr;
                zeroExt   = 1'b1;
            end
            opLw: begin
                regWriteD = 1'b1;
                memReadD  = 1'b1;
                memToRegD = 1'b1;
                aluSrcD   = 1'b1;
            end
            opSw: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                usesRt    = 1'b1;
            end
            opBeq: begin
                isBeq  = 1'b1;
                usesRt = 1'b1;
            end
            opBne: begin
                isBne  = 1'b1;
                usesRt = 1'b1;
            end
            opJ: isJump = 1'b1;
            opJal: begin
                isJump    = 1'b1;
                linkD     = 1'b1;
                regWriteD = 1'b1;
            end
            default: ;
        endcase
    end

    // Destination is rd, rt, or r31 for jal
    assign writeRegD = linkD ? linkReg : (useRd ? rd : rt);
    assign immD = zeroExt ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

    //////////////////////////////////////////////////////////////////////
    // Register file with writeback bypass
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (regWriteW && (writeRegW != '0)) begin
            regFile[writeRegW] <= writeDataW;
        end
    end

    assign readData1D = (rs == '0) ? '0 :
                        (regWriteW && (writeRegW == rs)) ? writeDataW : regFile[rs];
    assign readData2D = (rt == '0) ? '0 :
                        (regWriteW && (writeRegW == rt)) ? writeDataW : regFile[rt];

    // RAW check against execute and memory, jumps read nothing
    assign rsHazard = !isJump && (rs != '0) &&
                      ((regWriteEx && (writeRegEx == rs)) ||
                       (regWriteMem && (writeRegMem == rs)));
    assign rtHazard = usesRt && (rt != '0) &&
                      ((regWriteEx && (writeRegEx == rt)) ||
                       (regWriteMem && (writeRegMem == rt)));
    assign stall = rsHazard || rtHazard;

    // Branch resolution
    assign branchTaken    = (isBeq && (readData1D == readData2D)) ||
                            (isBne && (readData1D != readData2D));
    assign branchTarget   = pcPlus4D + {immD[29:0], 2'b00};
    assign jumpTarget     = {pcPlus4D[31:28], instrD[25:0], 2'b00};
    assign redirect       = (branchTaken || isJump) && !stall;
    assign redirectTarget = isJump ? jumpTarget : branchTarget;

    //////////////////////////////////////////////////////////////////////
    // Decode to execute register
    //////////////////////////////////////////////////////////////////////

    // Stall drops a bubble into execute
    always_ff @(posedge Clk) begin
        if (reset || stall) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            memToRegE <= 1'b0;
            linkE     <= 1'b0;
        end else begin
            regWriteE <= regWriteD;
            memReadE  <= memReadD;
            memWriteE <= memWriteD;
            memToRegE <= memToRegD;
            linkE     <= linkD;
        end
    end

    always_ff @(posedge Clk) begin
        aluOpE     <= aluOpD;
        aluSrcE    <= aluSrcD;
        shamtE     <= instrD[10:6];
        readData1E <= readData1D;
        readData2E <= readData2D;
        immE       <= immD;
        writeRegE  <= writeRegD;
        pcPlus4E   <= pcPlus4D;
    end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic             Clk,
    input  logic             reset,
    input  logic             regWriteE,
    input  logic             memReadE,
    input  logic             memWriteE,
    input  logic             memToRegE,
    input  logic             linkE,
    input  mipsPkg::aluOpT   aluOpE,
    input  logic             aluSrcE,
    input  logic [4:0]       shamtE,
    input  mipsPkg::wordT    readData1E,
    input  mipsPkg::wordT    readData2E,
    input  mipsPkg::wordT    immE,
    input  mipsPkg::regAddrT writeRegE,
    input  mipsPkg::wordT    pcPlus4E,
    output mipsPkg::wordT    aluResultM,
    output mipsPkg::wordT    storeDataM,
    output mipsPkg::regAddrT writeRegM,
    output logic             regWriteM,
    output logic             memReadM,
    output logic             memWriteM,
    output logic             memToRegM,
    output logic             linkM,
    output mipsPkg::wordT    pcPlus4M
);
    import mipsPkg::*;

    wordT srcB;
    wordT aluResultE;

    assign srcB = aluSrcE ? immE : readData2E;

    // ALU, sll shifts rt by the shamt field
    always_comb begin
        case (aluOpE)
            aluAdd:  aluResultE = readData1E + srcB;
            aluSub:  aluResultE = readData1E - srcB;
            aluAnd:  aluResultE = readData1E & srcB;
            aluOr:   aluResultE = readData1E | srcB;
            aluSlt:  aluResultE = {31'b0, $signed(readData1E) < $signed(srcB)};
            aluSll:  aluResultE = srcB << shamtE;
            default: aluResultE = srcB;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Execute to memory register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            memToRegM <= 1'b0;
            linkM     <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
            memToRegM <= memToRegE;
            linkM     <= linkE;
        end
    end

    always_ff @(posedge Clk) begin
        aluResultM <= aluResultE;
        storeDataM <= readData2E;
        writeRegM  <= writeRegE;
        pcPlus4M   <= pcPlus4E;
    end

endmodule

// File: verilog/memoryWriteback.sv
`timescale 1ns/1ps

module memoryWriteback (
    input  logic             Clk,
    input  logic             reset,
    input  mipsPkg::wordT    aluResultM,
    input  mipsPkg::wordT    storeDataM,
    input  mipsPkg::regAddrT writeRegM,
    input  logic             regWriteM,
    input  logic             memReadM,
    input  logic             memWriteM,
    input  logic             memToRegM,
    input  logic             linkM,
    input  mipsPkg::wordT    pcPlus4M,
    // Register file write port
    output logic             regWriteW,
    output mipsPkg::regAddrT writeRegW,
    output mipsPkg::wordT    writeDataW,
    // Display
    output mipsPkg::wordT    pcDisplay,
    output mipsPkg::wordT    writeDataDisplay,
    output mipsPkg::regAddrT retireReg,
    output logic             retireValid
);
    import mipsPkg::*;

    wordT readDataW;
    wordT aluResultW;
    wordT pcPlus4W;
    logic memToRegW;
    logic linkW;
    logic retiring;
    logic [dmemAddrBits-1:0] dmemIndex;

    wordT dmem [dmemWords];

    // Word addressed, low two bits dropped
    assign dmemIndex = aluResultM[dmemAddrBits+1:2];

    always_ff @(posedge Clk) begin
        if (memWriteM) begin
            dmem[dmemIndex] <= storeDataM;
        end
        if (memReadM) begin
            readDataW <= dmem[dmemIndex];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory to writeback register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
            linkW     <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
            linkW     <= linkM;
        end
    end

    always_ff @(posedge Clk) begin
        aluResultW <= aluResultM;
        writeRegW  <= writeRegM;
        pcPlus4W   <= pcPlus4M;
    end

    // jal links the address after itself
    assign writeDataW = linkW ? pcPlus4W : (memToRegW ? readDataW : aluResultW);

    // Display follows every real register write
    assign retiring = regWriteW && (writeRegW != '0);

    always_ff @(posedge Clk) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= retiring;
        end
    end

    always_ff @(posedge Clk) begin
        if (retiring) begin
            pcDisplay        <= pcPlus4W - 32'd4;
            writeDataDisplay <= writeDataW;
            retireReg        <= writeRegW;
        end
    end

endmodule

// File: verilog/mipsPipeline.sv
`timescale 1ns/1ps

module mipsPipeline (
    input  logic             Clk,
    input  logic             reset,
    output mipsPkg::wordT    pcDisplay,
    output mipsPkg::wordT    writeDataDisplay,
    output mipsPkg::regAddrT retireReg,
    output logic             retireValid
);
    import mipsPkg::*;

    // Fetch and decode
    wordT    instrD;
    wordT    pcPlus4D;
    wordT    redirectTarget;
    logic    stall;
    logic    redirect;

    // Execute
    logic    regWriteE;
    logic    memReadE;
    logic    memWriteE;
    logic    memToRegE;
    logic    linkE;
    aluOpT   aluOpE;
    logic    aluSrcE;
    logic [4:0] shamtE;
    wordT    readData1E;
    wordT    readData2E;
    wordT    immE;
    regAddrT writeRegE;
    wordT    pcPlus4E;

    // Memory
    wordT    aluResultM;
    wordT    storeDataM;
    regAddrT writeRegM;
    logic    regWriteM;
    logic    memReadM;
    logic    memWriteM;
    logic    memToRegM;
    logic    linkM;
    wordT    pcPlus4M;

    // Writeback
    logic    regWriteW;
    regAddrT writeRegW;
    wordT    writeDataW;

    fetchStage fetch_i (
        .Clk            (Clk),
        .reset          (reset),
        .stall          (stall),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .instrD         (instrD),
        .pcPlus4D       (pcPlus4D)
    );

    decodeStage decode_i (
        .Clk            (Clk),
        .reset          (reset),
        .instrD         (instrD),
        .pcPlus4D       (pcPlus4D),
        .writeRegEx     (writeRegE),
        .regWriteEx     (regWriteE),
        .writeRegMem    (writeRegM),
        .regWriteMem    (regWriteM),
        .regWriteW      (regWriteW),
        .writeRegW      (writeRegW),
        .writeDataW     (writeDataW),
        .stall          (stall),
        .redirect       (redirect),
        .redirectTarget (redirectTarget),
        .regWriteE      (regWriteE),
        .memReadE       (memReadE),
        .memWriteE      (memWriteE),
        .memToRegE      (memToRegE),
        .linkE          (linkE),
        .aluOpE         (aluOpE),
        .aluSrcE        (aluSrcE),
        .shamtE         (shamtE),
        .readData1E     (readData1E),
        .readData2E     (readData2E),
        .immE           (immE),
        .writeRegE      (writeRegE),
        .pcPlus4E       (pcPlus4E)
    );

    executeStage execute_i (
        .Clk        (Clk),
        .reset      (reset),
        .regWriteE  (regWriteE),
        .memReadE   (memReadE),
        .memWriteE  (memWriteE),
        .memToRegE  (memToRegE),
        .linkE      (linkE),
        .aluOpE     (aluOpE),
        .aluSrcE    (aluSrcE),
        .shamtE     (shamtE),
        .readData1E (readData1E),
        .readData2E (readData2E),
        .immE       (immE),
        .writeRegE  (writeRegE),
        .pcPlus4E   (pcPlus4E),
        .aluResultM (aluResultM),
        .storeDataM (storeDataM),
        .writeRegM  (writeRegM),
        .regWriteM  (regWriteM),
        .memReadM   (memReadM),
        .memWriteM  (memWriteM),
        .memToRegM  (memToRegM),
        .linkM      (linkM),
        .pcPlus4M   (pcPlus4M)
    );

    memoryWriteback memWb_i (
        .Clk              (Clk),
        .reset            (reset),
        .aluResultM       (aluResultM),
        .storeDataM       (storeDataM),
        .writeRegM        (writeRegM),
        .regWriteM        (regWriteM),
        .memReadM         (memReadM),
        .memWriteM        (memWriteM),
        .memToRegM        (memToRegM),
        .linkM            (linkM),
        .pcPlus4M         (pcPlus4M),
        .regWriteW        (regWriteW),
        .writeRegW        (writeRegW),
        .writeDataW       (writeDataW),
        .pcDisplay        (pcDisplay),
        .writeDataDisplay (writeDataDisplay),
        .retireReg        (retireReg),
        .retireValid      (retireValid)
    );

endmodule

// File: testbench/mipsPipeline_props.sv
`timescale 1ns/1ps

module mipsPipelineProps (
    input logic             Clk,
    input logic             reset,
    input mipsPkg::wordT    pcDisplay,
    input mipsPkg::regAddrT retireReg,
    input logic             retireValid
);

    // Nothing retires while reset is held
    retireQuietInReset: assert property (@(posedge Clk) reset |=> !retireValid)
        else $error("retireValid high during reset");

    // r0 writes never show up on the display
    retireRegNonzero: assert property (
        @(posedge Clk) disable iff (reset) retireValid |-> (retireReg != '0))
        else $error("retire pulse with register 0");

    retirePcAligned: assert property (
        @(posedge Clk) disable iff (reset) retireValid |-> (pcDisplay[1:0] == 2'b00))
        else $error("retired pc not word aligned");

endmodule

bind mipsPipeline mipsPipelineProps props_i (
    .Clk         (Clk),
    .reset       (reset),
    .pcDisplay   (pcDisplay),
    .retireReg   (retireReg),
    .retireValid (retireValid)
);

// File: testbench/mipsPipelineTb.sv
`timescale 1ns/1ps

module mipsPipelineTb;
    import mipsPkg::*;

    localparam int numRows     = 16;
    localparam int numGroups   = 5;
    localparam int cycleLimit  = 8 * numRows + 50;
    localparam int quietCycles = 20;

    logic    Clk;
    logic    reset;
    wordT    pcDisplay;
    wordT    writeDataDisplay;
    regAddrT retireReg;
    logic    retireValid;

    // Expected retire stream, program order
    int      rowGroup [numRows];
    wordT    rowPc    [numRows];
    regAddrT rowReg   [numRows];
    wordT    rowValue [numRows];
    string   groupName [numGroups];
    int      rowCount;

    int   errorCount;
    int   groupErrors;
    int   groupsOk;
    int   cycleCount;
    logic timedOut;

    mipsPipeline mipsPipeline_i (
        .Clk              (Clk),
        .reset            (reset),
        .pcDisplay        (pcDisplay),
        .writeDataDisplay (writeDataDisplay),
        .retireReg        (retireReg),
        .retireValid      (retireValid)
    );

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    task automatic addRow(input int group, input wordT pc, input regAddrT regNum,
                          input wordT value);
        rowGroup[rowCount] = group;
        rowPc[rowCount]    = pc;
        rowReg[rowCount]   = regNum;
        rowValue[rowCount] = value;
        rowCount++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Hand-worked results of program.hex
    //////////////////////////////////////////////////////////////////////
    task automatic buildTable();
        groupName[0] = "ALU operations";
        groupName[1] = "dependent instructions";
        groupName[2] = "store then load";
        groupName[3] = "branches";
        groupName[4] = "jumps and register 0";
        addRow(0, 32'h00, 5'd1,  32'h0000_0005);
        addRow(0, 32'h04, 5'd2,  32'hFFFF_FFFD);
        addRow(0, 32'h08, 5'd3,  32'h0000_00F8);
        addRow(0, 32'h0C, 5'd4,  32'h0000_0002);
        addRow(0, 32'h10, 5'd5,  32'h0000_0008);
        addRow(0, 32'h14, 5'd6,  32'h0000_0008);
        addRow(0, 32'h18, 5'd7,  32'h0000_00FA);
        addRow(0, 32'h1C, 5'd8,  32'h0000_0001);
        addRow(0, 32'h20, 5'd9,  32'h0000_0050);
        addRow(1, 32'h24, 5'd10, 32'h0000_0051);
        addRow(1, 32'h28, 5'd10, 32'h0000_00A2);
        addRow(2, 32'h30, 5'd11, 32'h0000_00A2);
        addRow(2, 32'h34, 5'd12, 32'h0000_00A7);
        // beq skips 0x3C, bne falls through
        addRow(3, 32'h44, 5'd13, 32'h0000_0007);
        addRow(4, 32'h48, 5'd31, 32'h0000_004C);
        addRow(4, 32'h5C, 5'd16, 32'h0000_0053);
    endtask

    // Compare one retire with its table row
    task automatic checkRetire(input int row);
        assert (pcDisplay == rowPc[row]) else begin
            $display("ERR %0t: row %0d pc %h, expected %h", $time, row, pcDisplay, rowPc[row]);
            groupErrors++;
        end
        assert (retireReg == rowReg[row]) else begin
            $display("ERR %0t: row %0d reg %0d, expected %0d", $time, row, retireReg,
                     rowReg[row]);
            groupErrors++;
        end
        assert (writeDataDisplay == rowValue[row]) else begin
            $display("ERR %0t: row %0d value %h, expected %h", $time, row,
                     writeDataDisplay, rowValue[row]);
            groupErrors++;
        end
    endtask

    task automatic finishGroup(input int group);
        if (groupErrors == 0) begin
            $display("Test %0d %s: ok", group + 1, groupName[group]);
            groupsOk++;
        end else begin
            $display("Test %0d %s: FAILED, %0d mismatches", group + 1, groupName[group],
                     groupErrors);
        end
        errorCount += groupErrors;
        groupErrors = 0;
    endtask

    initial begin
        int row;
        reset       = 1'b1;
        rowCount    = 0;
        errorCount  = 0;
        groupErrors = 0;
        groupsOk    = 0;
        cycleCount  = 0;
        timedOut    = 1'b0;
        row         = 0;
        buildTable();
        repeat (10) @(posedge Clk);
        @(negedge Clk);
        reset = 1'b0;

        // Display is stable at the falling edge
        while ((row < rowCount) && !timedOut) begin
            @(negedge Clk);
            cycleCount++;
            if (retireValid) begin
                checkRetire(row);
                if ((row == rowCount - 1) || (rowGroup[row + 1] != rowGroup[row])) begin
                    finishGroup(rowGroup[row]);
                end
                row++;
            end
            if (cycleCount >= cycleLimit) begin
                timedOut = 1'b1;
                $display("Timeout: retire stream stopped after %0d of %0d rows", row,
                         rowCount);
            end
        end

        // Program ends in a self loop, nothing more may retire
        if (!timedOut) begin
            repeat (quietCycles) begin
                @(negedge Clk);
                assert (!retireValid) else begin
                    $display("ERR %0t: extra retire of reg %0d at pc %h", $time,
                             retireReg, pcDisplay);
                    errorCount++;
                end
            end
        end

        $display("Tests: %0d ok, %0d failed, %0d mismatches", groupsOk,
                 numGroups - groupsOk, errorCount);
        if (timedOut || (errorCount != 0)) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

// File: mipsPipeline.f
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryWriteback.sv
verilog/mipsPipeline.sv
testbench/mipsPipeline_props.sv
testbench/mipsPipelineTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsPipelineTb
FILELIST  = mipsPipeline.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM) program.hex
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)

// File: program.hex
// One instruction word per line, starting at byte address 0x00
// Layout: ALU ops, dependent chain, sw/lw, beq/bne, jal/j/r0 write, end loop
24010005
2402FFFD
340300F8
00222021
00222823
00653024
00643825
0041402A
00014900
01285021
014A5021
AC0A0008
8C0B0008
01616021
10210001
240D0001
14210001
240D0007
0C000014
240E0011
24000009
08000017
240F0033
03ED8021
08000018
